// File: rtl/lsq_pkg.sv
package lsq_pkg;

  // ========================================
  // Entry layout
  // ========================================
  localparam int DATA_BITS  = 128;
  localparam int BE_BITS    = 8;
  localparam int ENTRY_BITS = DATA_BITS + BE_BITS + 1;

  // ========================================
  // Addressing and port counts
  // ========================================
  localparam int ADDR_BITS   = 8;
  localparam int ROW_BITS    = ADDR_BITS - 1;
  localparam int ROW_COUNT   = 120;           // Rows per bank.
  localparam int ENTRY_COUNT = 2 * ROW_COUNT;
  localparam int WR_LANES    = 2;
  localparam int RD_PORTS    = 2;
  localparam int CLR_SLOTS   = 2;             // Per bank, per cycle.
  localparam int ALLOC_MAX   = 3;             // Longest allocation run.

  // Enable bit i covers byte i of each 64-bit half.
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic [BE_BITS-1:0]   byte_en;
    logic                 split;
  } lsq_entry_t;

  // Number of consecutive entries cleared from the base.
  typedef enum logic [1:0] {
    ALLOC_NONE  = 2'd0,
    ALLOC_ONE   = 2'd1,
    ALLOC_TWO   = 2'd2,
    ALLOC_THREE = 2'd3
  } alloc_op_e;

endpackage

// File: rtl/lsq_bank_if.sv
`timescale 1ns/1ps

interface lsq_bank_if;
  import lsq_pkg::*;

  // Store-data writes, one per lane.
  logic [WR_LANES-1:0]  wr_en;
  logic [ROW_BITS-1:0]  wr_row [WR_LANES];
  lsq_entry_t           wr_entry [WR_LANES];

  // Row clears, one per slot.
  logic [CLR_SLOTS-1:0] clr_en;
  logic [ROW_BITS-1:0]  clr_row [CLR_SLOTS];

  modport req (
    output wr_en,
    output wr_row,
    output wr_entry,
    output clr_en,
    output clr_row
  );

  modport bank (
    input wr_en,
    input wr_row,
    input wr_entry,
    input clr_en,
    input clr_row
  );

endinterface

// File: rtl/lsq_alloc_decode.sv
`timescale 1ns/1ps

module lsq_alloc_decode (
  input  logic [lsq_pkg::WR_LANES-1:0]  wr_en,
  input  logic [lsq_pkg::ADDR_BITS-1:0] wr_addr [lsq_pkg::WR_LANES],
  input  lsq_pkg::lsq_entry_t           wr_entry [lsq_pkg::WR_LANES],
  input  lsq_pkg::alloc_op_e            alloc_op,
  input  logic [lsq_pkg::ADDR_BITS-1:0] alloc_base,
  input  logic                          init_busy,
  lsq_bank_if.req                       even_req,
  lsq_bank_if.req                       odd_req
);
  import lsq_pkg::*;

  logic [ADDR_BITS-1:0] alloc_addr [ALLOC_MAX];
  logic [ALLOC_MAX-1:0] alloc_hit;
  logic                 base_odd;

  // ========================================
  // Write lane steering
  // ========================================
  for (genvar l = 0; l < WR_LANES; l++) begin : g_lane
    assign even_req.wr_en[l]    = wr_en[l] && !init_busy && !wr_addr[l][0];
    assign odd_req.wr_en[l]     = wr_en[l] && !init_busy && wr_addr[l][0];
    assign even_req.wr_row[l]   = wr_addr[l][ADDR_BITS-1:1];
    assign odd_req.wr_row[l]    = wr_addr[l][ADDR_BITS-1:1];
    assign even_req.wr_entry[l] = wr_entry[l];
    assign odd_req.wr_entry[l]  = wr_entry[l];
  end

  // ========================================
  // Allocation expansion
  // ========================================
  always_comb begin
    for (int k = 0; k < ALLOC_MAX; k++) begin
      alloc_addr[k] = alloc_base + ADDR_BITS'(k);
      alloc_hit[k]  = !init_busy && (k < int'(alloc_op));
    end
  end

  // Entries 0 and 2 share the base bank, entry 1 lands in the other.
  assign base_odd = alloc_base[0];

  assign even_req.clr_en[0]  = base_odd ? alloc_hit[1] : alloc_hit[0];
  assign even_req.clr_row[0] = base_odd ? alloc_addr[1][ADDR_BITS-1:1]
                                        : alloc_addr[0][ADDR_BITS-1:1];
  assign even_req.clr_en[1]  = !base_odd && alloc_hit[2];
  assign even_req.clr_row[1] = alloc_addr[2][ADDR_BITS-1:1];

  assign odd_req.clr_en[0]   = base_odd ? alloc_hit[0] : alloc_hit[1];
  assign odd_req.clr_row[0]  = base_odd ? alloc_addr[0][ADDR_BITS-1:1]
                                        : alloc_addr[1][ADDR_BITS-1:1];
  assign odd_req.clr_en[1]   = base_odd && alloc_hit[2];
  assign odd_req.clr_row[1]  = alloc_addr[2][ADDR_BITS-1:1];

  // ========================================
  // Checks
  // ========================================
  always_comb begin
    if (!init_busy) begin
      assert final (!(wr_en[0] && wr_en[1] && wr_addr[0] == wr_addr[1]))
        else $error("Both lanes write entry %0d", wr_addr[0]);
      assert final (alloc_op == ALLOC_NONE ||
                    ({1'b0, alloc_base} + 9'(alloc_op)) <= 9'(ENTRY_COUNT))
        else $error("Allocation from %0d runs past the queue", alloc_base);
    end
  end

endmodule

// File: rtl/lsq_bank_ram.sv
`timescale 1ns/1ps

module lsq_bank_ram (
  input  logic                         clk,
  input  logic [lsq_pkg::ROW_BITS-1:0] rd_row [lsq_pkg::RD_PORTS],
  output lsq_pkg::lsq_entry_t          rd_entry [lsq_pkg::RD_PORTS],
  lsq_bank_if.bank                     port
);
  import lsq_pkg::*;

  localparam lsq_entry_t ZERO_ENTRY = lsq_entry_t'({ENTRY_BITS{1'b0}});

  lsq_entry_t mem [ROW_COUNT];

  for (genvar p = 0; p < RD_PORTS; p++) begin : g_rd
    assign rd_entry[p] = mem[rd_row[p]];
  end

  // Lane 0, then lane 1, then clears. Last write wins.
  always_ff @(posedge clk) begin
    for (int l = 0; l < WR_LANES; l++) begin
      if (port.wr_en[l]) begin
        mem[port.wr_row[l]] <= port.wr_entry[l];
      end
    end
    for (int s = 0; s < CLR_SLOTS; s++) begin
      if (port.clr_en[s]) begin
        mem[port.clr_row[s]] <= ZERO_ENTRY;
      end
    end
  end

  for (genvar l = 0; l < WR_LANES; l++) begin : g_wr_chk
    a_wr_row: assert property (@(posedge clk)
      port.wr_en[l] |-> port.wr_row[l] < ROW_BITS'(ROW_COUNT));
  end

  for (genvar s = 0; s < CLR_SLOTS; s++) begin : g_clr_chk
    a_clr_row: assert property (@(posedge clk)
      port.clr_en[s] |-> port.clr_row[s] < ROW_BITS'(ROW_COUNT));
  end

endmodule

// File: rtl/lsq_data_store.sv
`timescale 1ns/1ps

module lsq_data_store (
  input  logic                          clk,
  input  logic                          rst,
  lsq_bank_if.bank                      even_req,
  lsq_bank_if.bank                      odd_req,
  input  logic [lsq_pkg::ADDR_BITS-1:0] rd_addr [lsq_pkg::RD_PORTS],
  output lsq_pkg::lsq_entry_t           rd_entry [lsq_pkg::RD_PORTS],
  output logic                          init_busy
);
  import lsq_pkg::*;

  logic [ROW_BITS-1:0] sweep_row;
  logic [ROW_BITS-1:0] rd_row [RD_PORTS];
  lsq_entry_t          even_rd [RD_PORTS];
  lsq_entry_t          odd_rd [RD_PORTS];

  lsq_bank_if even_mem ();
  lsq_bank_if odd_mem ();

  // ========================================
  // Init sweep
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      init_busy <= 1'b1;
      sweep_row <= '0;
    end else if (init_busy) begin
      sweep_row <= sweep_row + 1'b1;
      if (sweep_row == ROW_BITS'(ROW_COUNT - 1)) begin
        init_busy <= 1'b0;                    // Last row cleared.
      end
    end
  end

  // Sweep takes over clear slot 1 in both banks.
  assign even_mem.wr_en      = even_req.wr_en;
  assign even_mem.wr_row     = even_req.wr_row;
  assign even_mem.wr_entry   = even_req.wr_entry;
  assign even_mem.clr_en[0]  = even_req.clr_en[0];
  assign even_mem.clr_row[0] = even_req.clr_row[0];
  assign even_mem.clr_en[1]  = init_busy || even_req.clr_en[1];
  assign even_mem.clr_row[1] = init_busy ? sweep_row : even_req.clr_row[1];

  assign odd_mem.wr_en       = odd_req.wr_en;
  assign odd_mem.wr_row      = odd_req.wr_row;
  assign odd_mem.wr_entry    = odd_req.wr_entry;
  assign odd_mem.clr_en[0]   = odd_req.clr_en[0];
  assign odd_mem.clr_row[0]  = odd_req.clr_row[0];
  assign odd_mem.clr_en[1]   = init_busy || odd_req.clr_en[1];
  assign odd_mem.clr_row[1]  = init_busy ? sweep_row : odd_req.clr_row[1];

  // ========================================
  // Banks and read select
  // ========================================
  for (genvar p = 0; p < RD_PORTS; p++) begin : g_rd
    assign rd_row[p]   = rd_addr[p][ADDR_BITS-1:1];
    assign rd_entry[p] = rd_addr[p][0] ? odd_rd[p] : even_rd[p];
  end

  lsq_bank_ram u_even_bank (
    .clk      (clk),
    .rd_row   (rd_row),
    .rd_entry (even_rd),
    .port     (even_mem.bank)
  );

  lsq_bank_ram u_odd_bank (
    .clk      (clk),
    .rd_row   (rd_row),
    .rd_entry (odd_rd),
    .port     (odd_mem.bank)
  );

  // Decode must stay quiet while the sweep owns the banks.
  a_quiet_init: assert property (@(posedge clk) disable iff (rst)
    init_busy |-> !(|even_req.wr_en) && !(|odd_req.wr_en) &&
                  !(|even_req.clr_en) && !(|odd_req.clr_en));

endmodule

// File: rtl/lsq_read_result.sv
`timescale 1ns/1ps

module lsq_read_result (
  input  logic                         clk,
  input  logic                         rst,
  input  lsq_pkg::lsq_entry_t          rd_entry_in [lsq_pkg::RD_PORTS],
  output lsq_pkg::lsq_entry_t          rd_entry [lsq_pkg::RD_PORTS],
  output logic [lsq_pkg::RD_PORTS-1:0] rd_hit
);
  import lsq_pkg::*;

  localparam int BYTES = DATA_BITS / 8;

  logic [DATA_BITS-1:0] keep [RD_PORTS];
  lsq_entry_t           masked [RD_PORTS];

  // Byte b follows enable bit b mod 8, so both halves share the mask.
  always_comb begin
    for (int p = 0; p < RD_PORTS; p++) begin
      for (int b = 0; b < BYTES; b++) begin
        keep[p][8*b +: 8] = {8{rd_entry_in[p].byte_en[b % BE_BITS]}};
      end
      masked[p]      = rd_entry_in[p];
      masked[p].data = rd_entry_in[p].data & keep[p];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < RD_PORTS; p++) begin
        rd_entry[p] <= '0;
      end
      rd_hit <= '0;
    end else begin
      for (int p = 0; p < RD_PORTS; p++) begin
        rd_entry[p] <= masked[p];
        rd_hit[p]   <= |rd_entry_in[p].byte_en;  // Any byte enabled.
      end
    end
  end

endmodule

// File: rtl/lsq_data_top.sv
`timescale 1ns/1ps

module lsq_data_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [lsq_pkg::WR_LANES-1:0]  wr_en,
  input  logic [lsq_pkg::ADDR_BITS-1:0] wr_addr [lsq_pkg::WR_LANES],
  input  lsq_pkg::lsq_entry_t           wr_entry [lsq_pkg::WR_LANES],
  input  lsq_pkg::alloc_op_e            alloc_op,
  input  logic [lsq_pkg::ADDR_BITS-1:0] alloc_base,
  input  logic [lsq_pkg::ADDR_BITS-1:0] rd_addr [lsq_pkg::RD_PORTS],
  output lsq_pkg::lsq_entry_t           rd_entry [lsq_pkg::RD_PORTS],
  output logic [lsq_pkg::RD_PORTS-1:0]  rd_hit,
  output logic                          init_busy
);
  import lsq_pkg::*;

  lsq_entry_t store_rd [RD_PORTS];

  lsq_bank_if even_if ();
  lsq_bank_if odd_if ();

  lsq_alloc_decode u_decode (
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_entry   (wr_entry),
    .alloc_op   (alloc_op),
    .alloc_base (alloc_base),
    .init_busy  (init_busy),
    .even_req   (even_if.req),
    .odd_req    (odd_if.req)
  );

  lsq_data_store u_store (
    .clk       (clk),
    .rst       (rst),
    .even_req  (even_if.bank),
    .odd_req   (odd_if.bank),
    .rd_addr   (rd_addr),
    .rd_entry  (store_rd),
    .init_busy (init_busy)
  );

  // One register stage to the outputs.
  lsq_read_result u_result (
    .clk         (clk),
    .rst         (rst),
    .rd_entry_in (store_rd),
    .rd_entry    (rd_entry),
    .rd_hit      (rd_hit)
  );

endmodule

// File: test/tb_lsq_tests.svh
// ========================================
// Directed tests
// ========================================
task automatic check_init_sweep();
  int busy_cycles;
  busy_cycles = 0;
  for (int p = 0; p < RD_PORTS; p++) begin
    check_value($sformatf("rd_entry[%0d] after reset", p), '0, rd_entry[p]);
    check_value($sformatf("rd_hit[%0d] after reset", p), 1'b0, rd_hit[p]);
  end
  while (init_busy === 1'b1 && busy_cycles < 2 * ROW_COUNT) begin
    busy_cycles++;
    next_cycle();
  end
  check_value("init_busy high cycles", ROW_COUNT, busy_cycles);
  for (int i = 0; i < 8; i++) begin
    rd_addr[0] = rand_addr();
    rd_addr[1] = rand_addr();
    run_cycle();                                        // Model is all zero here.
    check_value("init_busy", 1'b0, init_busy);
  end
endtask

task automatic masked_write_read();
  logic [ADDR_BITS-1:0] a;
  logic [ADDR_BITS-1:0] b;
  a              = rand_addr();
  b              = ADDR_BITS'((int'(a) + 7) % ENTRY_COUNT);
  wr_entry[0]    = rand_entry();
  wr_entry[0].byte_en = 8'b1010_0101;
  wr_entry[0].split   = 1'b1;
  wr_entry[1]    = rand_entry();
  wr_entry[1].byte_en = 8'h00;                          // No byte enabled.
  wr_addr[0]     = a;
  wr_addr[1]     = b;
  wr_en          = 2'b11;
  run_cycle();
  rd_addr[0] = a;
  rd_addr[1] = b;
  run_cycle();
  check_value("rd_hit[0] partial enable", 1'b1, rd_hit[0]);
  check_value("rd_hit[1] no enable", 1'b0, rd_hit[1]);
endtask

task automatic dual_lane_writes();
  logic [ADDR_BITS-1:0] ea;
  logic [ADDR_BITS-1:0] oa;
  ea          = rand_addr() & 8'hFE;
  oa          = rand_addr() | 8'h01;
  wr_addr[0]  = ea;
  wr_addr[1]  = oa;
  wr_entry[0] = rand_entry();
  wr_entry[1] = rand_entry();
  wr_en       = 2'b11;
  run_cycle();
  rd_addr[0] = ea;
  rd_addr[1] = oa;
  run_cycle();
  // Both lanes into the even bank at different rows.
  wr_addr[1]  = ADDR_BITS'((int'(ea) + 4) % ENTRY_COUNT);
  wr_entry[0] = rand_entry();
  wr_entry[1] = rand_entry();
  wr_en       = 2'b11;
  run_cycle();
  rd_addr[0] = ea;
  rd_addr[1] = wr_addr[1];
  run_cycle();
endtask

task automatic fill_pair(input logic [ADDR_BITS-1:0] a0, input logic [ADDR_BITS-1:0] a1,
                         input logic [WR_LANES-1:0] lanes);
  wr_addr[0]  = a0;
  wr_addr[1]  = a1;
  wr_entry[0] = rand_entry();
  wr_entry[1] = rand_entry();
  wr_entry[0].byte_en[0] = 1'b1;                        // Keep hit high.
  wr_entry[1].byte_en[0] = 1'b1;
  wr_en       = lanes;
  run_cycle();
endtask

task automatic alloc_clears();
  logic [ADDR_BITS-1:0] base;
  int                   a;
  for (int op = 1; op <= ALLOC_MAX; op++) begin
    for (int par = 0; par < 2; par++) begin
      base = ADDR_BITS'(60 * op + par);
      fill_pair(base - 1, base, 2'b11);
      fill_pair(base + 1, base + 2, 2'b11);
      fill_pair(base + 3, base + 3, 2'b01);
      alloc_op   = alloc_op_e'(op);
      alloc_base = base;
      run_cycle();
      for (int i = -1; i <= 3; i++) begin
        a          = int'(base) + i;
        rd_addr[0] = ADDR_BITS'(a);
        rd_addr[1] = ADDR_BITS'(a);
        run_cycle();
        check_value($sformatf("rd_hit[0] entry %0d alloc %0d", a, op),
                    !(i >= 0 && i < op), rd_hit[0]);
      end
    end
  end
endtask

task automatic clear_beats_write();
  logic [ADDR_BITS-1:0] a;
  a = ADDR_BITS'((lcg_next() >> 8) % (ENTRY_COUNT - 2));
  fill_pair(a, a + 1, 2'b11);
  wr_addr[0]          = a;
  wr_addr[1]          = a + 1;
  wr_entry[0]         = rand_entry();
  wr_entry[1]         = rand_entry();
  wr_entry[0].byte_en = 8'hFF;
  wr_entry[1].byte_en = 8'hFF;
  wr_en               = 2'b11;
  alloc_op            = ALLOC_TWO;
  alloc_base          = a;
  run_cycle();
  rd_addr[0] = a;
  rd_addr[1] = a + 1;
  run_cycle();
  check_value("rd_hit[0] cleared entry", 1'b0, rd_hit[0]);
  check_value("rd_hit[1] cleared entry", 1'b0, rd_hit[1]);
endtask

task automatic random_traffic();
  logic [31:0] r;
  for (int i = 0; i < 200; i++) begin
    r          = lcg_next();
    wr_en      = r[9:8];
    wr_addr[0] = rand_addr();
    wr_addr[1] = rand_addr();
    if (wr_addr[1] == wr_addr[0]) begin
      wr_addr[1] = ADDR_BITS'((int'(wr_addr[0]) + 1) % ENTRY_COUNT);
    end
    wr_entry[0] = rand_entry();
    wr_entry[1] = rand_entry();
    alloc_op    = (r[13:12] == 2'b00) ? alloc_op_e'(r[11:10]) : ALLOC_NONE;
    alloc_base  = ADDR_BITS'((lcg_next() >> 8) % (ENTRY_COUNT - 2));
    rd_addr[0]  = rand_addr();
    rd_addr[1]  = rand_addr();
    run_cycle();
  end
endtask

// File: test/tb_lsq_data.sv
`timescale 1ns/1ps

module tb_lsq_data;
  import lsq_pkg::*;

  localparam int CLK_HALF       = 10;
  localparam int DRIVE_DELAY    = 2;
  localparam int INIT_CYCLES    = 124;                  // Reset plus sweep.
  localparam int TEST_CYCLES    = 271;                  // All directed and random tests.
  localparam int TIMEOUT_CYCLES = INIT_CYCLES + TEST_CYCLES + 100;

  logic                 clk;
  logic                 rst;
  logic [WR_LANES-1:0]  wr_en;
  logic [ADDR_BITS-1:0] wr_addr [WR_LANES];
  lsq_entry_t           wr_entry [WR_LANES];
  alloc_op_e            alloc_op;
  logic [ADDR_BITS-1:0] alloc_base;
  logic [ADDR_BITS-1:0] rd_addr [RD_PORTS];
  lsq_entry_t           rd_entry [RD_PORTS];
  logic [RD_PORTS-1:0]  rd_hit;
  logic                 init_busy;

  lsq_entry_t  model [ENTRY_COUNT];                     // Flat view of the queue.
  logic [31:0] lcg_state;
  int          error_count;
  int          cycle_count;

  lsq_data_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_entry   (wr_entry),
    .alloc_op   (alloc_op),
    .alloc_base (alloc_base),
    .rd_addr    (rd_addr),
    .rd_entry   (rd_entry),
    .rd_hit     (rd_hit),
    .init_busy  (init_busy)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ========================================
  // Helpers
  // ========================================
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [ADDR_BITS-1:0] rand_addr();
    return ADDR_BITS'((lcg_next() >> 8) % ENTRY_COUNT);
  endfunction

  function automatic lsq_entry_t rand_entry();
    lsq_entry_t  e;
    logic [31:0] r;
    for (int w = 0; w < DATA_BITS / 32; w++) begin
      e.data[32*w +: 32] = lcg_next();
    end
    r         = lcg_next();
    e.byte_en = r[15:8];
    e.split   = r[20];
    return e;
  endfunction

  // Byte b of the data is kept only when enable bit b mod 8 is set.
  function automatic lsq_entry_t masked_view(lsq_entry_t e);
    lsq_entry_t v;
    v = e;
    for (int b = 0; b < DATA_BITS / 8; b++) begin
      if (!e.byte_en[b % BE_BITS]) begin
        v.data[8*b +: 8] = 8'h00;
      end
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [ENTRY_BITS-1:0] expected,
                             input logic [ENTRY_BITS-1:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // Lane 0, lane 1, then clears. The last one wins.
  task automatic apply_to_model();
    for (int l = 0; l < WR_LANES; l++) begin
      if (wr_en[l]) begin
        model[wr_addr[l]] = wr_entry[l];
      end
    end
    for (int k = 0; k < int'(alloc_op); k++) begin
      model[int'(alloc_base) + k] = '0;
    end
  endtask

  // Reads see the queue before this cycle's writes land.
  task automatic run_cycle();
    lsq_entry_t exp_entry [RD_PORTS];
    logic       exp_hit [RD_PORTS];
    for (int p = 0; p < RD_PORTS; p++) begin
      exp_entry[p] = masked_view(model[rd_addr[p]]);
      exp_hit[p]   = |model[rd_addr[p]].byte_en;
    end
    apply_to_model();
    next_cycle();
    for (int p = 0; p < RD_PORTS; p++) begin
      check_value($sformatf("rd_entry[%0d]", p), exp_entry[p], rd_entry[p]);
      check_value($sformatf("rd_hit[%0d]", p), exp_hit[p], rd_hit[p]);
    end
    wr_en    = '0;                                      // Strobes last one cycle.
    alloc_op = ALLOC_NONE;
  endtask

  `include "tb_lsq_tests.svh"

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    lcg_state   = 32'd93149;
    error_count = 0;
    cycle_count = 0;
    rst         = 1'b1;
    wr_en       = '0;
    alloc_op    = ALLOC_NONE;
    alloc_base  = '0;
    for (int l = 0; l < WR_LANES; l++) begin
      wr_addr[l]  = '0;
      wr_entry[l] = '0;
    end
    for (int p = 0; p < RD_PORTS; p++) begin
      rd_addr[p] = '0;
    end
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      model[i] = '0;                                    // Sweep clears everything.
    end
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    check_init_sweep();
    masked_write_read();
    dual_lane_writes();
    alloc_clears();
    clear_beats_write();
    random_traffic();

    $display("Run finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+test
rtl/lsq_pkg.sv
rtl/lsq_bank_if.sv
rtl/lsq_alloc_decode.sv
rtl/lsq_bank_ram.sv
rtl/lsq_data_store.sv
rtl/lsq_read_result.sv
rtl/lsq_data_top.sv
test/tb_lsq_data.sv

// File: Makefile
# Verilator build for the load-store queue data side.

VERILATOR ?= verilator
TOP       ?= tb_lsq_data
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv test/*.sv test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
